//--- files.f
+incdir+hdl
hdl/video_pkg.sv
hdl/buffer_pkg.sv
hdl/frame_writer.sv
hdl/pixel_bank.sv
hdl/frame_reader.sv
hdl/splicer_top.sv
verif/tb_splicer.sv

//--- run.sh
#!/bin/sh
# build and run the splicer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_splicer -Mdir obj_dir -f files.f

output=$(./obj_dir/Vtb_splicer || true)
echo "$output"

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
  exit 0
else
  exit 1
fi

//--- verif/tb_splicer.sv
`default_nettype none

`include "splicer_defines.svh"

module tb_splicer;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int frame_beats = `SPLICER_FRAME_BEATS;
  localparam int line_beats  = `SPLICER_LINE_BEATS;
  localparam int frame_count = 3;
  localparam int wait_limit  = 1000;

  logic             aclk    = 1'b0;
  logic             aresetn = 1'b0;
  video_pkg::beat_t s_axis_tdata;
  logic             s_axis_tvalid;
  logic             s_axis_tuser;
  logic             s_axis_tready;
  logic             s_axis_tlast;
  video_pkg::beat_t m_axis_tdata;
  logic             m_axis_tvalid;
  logic             m_axis_tready;
  logic             m_axis_tuser;
  logic             m_axis_tlast;

  logic [31:0]              lfsr_state = 32'h50d9;
  video_pkg::beat_t         exp_q [$];
  buffer_pkg::write_state_t wr_model = buffer_pkg::wait_sof;
  int                       wr_count = 0;
  int                       out_index = 0;
  int                       out_count = 0;
  int                       release_wait = 0;
  logic                     in_reset = 1'b1;
  logic                     stalled = 1'b0;
  video_pkg::beat_t         stall_data;
  logic                     stall_user;
  logic                     stall_last;

  splicer_top u_dut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast)
  );

  always #5 aclk = ~aclk;

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_beat(input string name, input video_pkg::beat_t got,
                            input video_pkg::beat_t exp);
    if (got !== exp) begin
      $display("[FAIL] time %0d ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] time %0d ns: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // one LFSR step per bit
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic video_pkg::beat_t random_beat();
    logic [31:0] even_bits;
    logic [31:0] odd_bits;
    even_bits = take_bits(`SPLICER_PIXEL_W);
    odd_bits  = take_bits(`SPLICER_PIXEL_W);
    return {odd_bits[`SPLICER_PIXEL_W-1:0], even_bits[`SPLICER_PIXEL_W-1:0]};
  endfunction

  // {tuser, tlast} for a beat position in the frame
  function automatic logic [1:0] expected_markers(input int index);
    logic user;
    logic last;
    user = (index == 0);
    // the beat after a line end starts a new line
    last = (((index + 1) % line_beats) == 0);
    return {user, last};
  endfunction

  // advance to just after the next rising edge, new back-pressure
  task automatic next_cycle();
    @(posedge aclk);
    #1;
    m_axis_tready = (take_bits(2) != 32'd0);
  endtask

  task automatic send_beat(input video_pkg::beat_t data, input logic user,
                           input logic last);
    int   idle;
    int   waited;
    logic accepted;
    idle = 0;
    // random idle cycles ahead of the beat
    while ((idle < 4) && (take_bits(2) == 32'd0)) begin
      s_axis_tvalid = 1'b0;
      next_cycle();
      idle++;
    end
    s_axis_tdata  = data;
    s_axis_tuser  = user;
    s_axis_tlast  = last;
    s_axis_tvalid = 1'b1;
    accepted = 1'b0;
    waited = 0;
    while (!accepted) begin
      @(negedge aclk);
      accepted = s_axis_tready;
      next_cycle();
      waited++;
      if (!accepted && (waited > wait_limit)) begin
        $display("timeout: input beat not accepted within %0d cycles", wait_limit);
        abort_run();
      end
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : drive
    int waited;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tuser  = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b1;
    repeat (5) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    // junk ahead of the first start of frame
    for (int i = 0; i < 3; i++) begin
      send_beat(random_beat(), 1'b0, 1'b0);
    end

    // frame 1 carries a stray tuser in the middle
    for (int f = 0; f < frame_count; f++) begin
      for (int b = 0; b < frame_beats; b++) begin
        send_beat(random_beat(), (b == 0) || ((f == 1) && (b == 5)),
                  (b % line_beats) == (line_beats - 1));
      end
    end
    s_axis_tvalid = 1'b0;
    s_axis_tuser  = 1'b0;
    s_axis_tlast  = 1'b0;

    waited = 0;
    while ((out_count < frame_count * frame_beats) && (waited < wait_limit)) begin
      next_cycle();
      waited++;
    end
    if ((out_count != frame_count * frame_beats) || (exp_q.size() != 0)) begin
      $display("timeout: %0d of %0d output beats seen, %0d still queued",
               out_count, frame_count * frame_beats, exp_q.size());
      abort_run();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

  ////////////////////
  // compare
  ////////////////////

  // sampled mid-cycle, a handshake here completes on the next rising edge
  always @(negedge aclk) begin : compare
    video_pkg::beat_t exp_beat;
    logic [1:0]       markers;
    if (!aresetn) begin
      check_flag("s_axis_tready", s_axis_tready, 1'b1);
      check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
      check_flag("m_axis_tuser", m_axis_tuser, 1'b0);
      check_flag("m_axis_tlast", m_axis_tlast, 1'b0);
      wr_model     = buffer_pkg::wait_sof;
      wr_count     = 0;
      out_index    = 0;
      release_wait = 0;
      stalled      = 1'b0;
      in_reset     = 1'b1;
    end else begin
      if (in_reset) begin
        check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_flag("m_axis_tuser", m_axis_tuser, 1'b0);
        check_flag("m_axis_tlast", m_axis_tlast, 1'b0);
        in_reset = 1'b0;
      end

      // writer leaves hold two samples after the last output beat
      if (release_wait > 0) begin
        release_wait--;
        if (release_wait == 0) begin
          wr_model = buffer_pkg::wait_sof;
        end
      end
      check_flag("s_axis_tready", s_axis_tready, wr_model != buffer_pkg::hold);

      if (stalled) begin
        check_flag("m_axis_tvalid", m_axis_tvalid, 1'b1);
        check_beat("m_axis_tdata", m_axis_tdata, stall_data);
        check_flag("m_axis_tuser", m_axis_tuser, stall_user);
        check_flag("m_axis_tlast", m_axis_tlast, stall_last);
      end

      // input side
      if (s_axis_tvalid && s_axis_tready) begin
        if (wr_model == buffer_pkg::wait_sof) begin
          if (s_axis_tuser) begin
            exp_q.push_back(s_axis_tdata);
            wr_count = 1;
            wr_model = buffer_pkg::fill;
          end
        end else if (wr_model == buffer_pkg::fill) begin
          exp_q.push_back(s_axis_tdata);
          wr_count++;
          if (wr_count == frame_beats) begin
            wr_model = buffer_pkg::hold;
          end
        end
      end

      // output side
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_q.size() == 0) begin
          $display("output beat at time %0d ns with no input beat left to match", $time);
          abort_run();
        end
        exp_beat = exp_q.pop_front();
        markers  = expected_markers(out_index);
        check_beat("m_axis_tdata", m_axis_tdata, exp_beat);
        check_flag("m_axis_tuser", m_axis_tuser, markers[1]);
        check_flag("m_axis_tlast", m_axis_tlast, markers[0]);
        out_count++;
        out_index++;
        if (out_index == frame_beats) begin
          out_index    = 0;
          release_wait = 2;
        end
      end

      stalled    = m_axis_tvalid && !m_axis_tready;
      stall_data = m_axis_tdata;
      stall_user = m_axis_tuser;
      stall_last = m_axis_tlast;
    end
  end

endmodule

`default_nettype wire

//--- hdl/splicer_top.sv
`default_nettype none

module splicer_top (
  input  wire logic              aclk,
  input  wire logic              aresetn,

  // input stream, tlast is recomputed and not used here
  input  wire video_pkg::beat_t  s_axis_tdata,
  input  wire logic              s_axis_tvalid,
  input  wire logic              s_axis_tuser,
  output logic                   s_axis_tready,
  input  wire logic              s_axis_tlast,

  // output stream
  output video_pkg::beat_t       m_axis_tdata,
  output logic                   m_axis_tvalid,
  input  wire logic              m_axis_tready,
  output logic                   m_axis_tuser,
  output logic                   m_axis_tlast
);

  logic                   wr_en;
  buffer_pkg::beat_addr_t wr_addr;
  video_pkg::pixel_t      wr_pixel_even;
  video_pkg::pixel_t      wr_pixel_odd;
  logic                   rd_en;
  buffer_pkg::beat_addr_t rd_addr;
  video_pkg::pixel_t      rd_pixel_even;
  video_pkg::pixel_t      rd_pixel_odd;
  logic                   frame_ready;
  logic                   frame_free;

  frame_writer u_writer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tuser  (s_axis_tuser),
    .frame_free    (frame_free),
    .s_axis_tready (s_axis_tready),
    .wr_en         (wr_en),
    .frame_ready   (frame_ready),
    .wr_addr       (wr_addr),
    .wr_pixel_even (wr_pixel_even),
    .wr_pixel_odd  (wr_pixel_odd)
  );

  ////////////////////
  // pixel banks
  ////////////////////

  pixel_bank u_bank_even (
    .aclk     (aclk),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .wr_addr  (wr_addr),
    .rd_addr  (rd_addr),
    .wr_pixel (wr_pixel_even),
    .rd_pixel (rd_pixel_even)
  );

  pixel_bank u_bank_odd (
    .aclk     (aclk),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .wr_addr  (wr_addr),
    .rd_addr  (rd_addr),
    .wr_pixel (wr_pixel_odd),
    .rd_pixel (rd_pixel_odd)
  );

  frame_reader u_reader (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .frame_ready   (frame_ready),
    .rd_pixel_even (rd_pixel_even),
    .rd_pixel_odd  (rd_pixel_odd),
    .m_axis_tready (m_axis_tready),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .frame_free    (frame_free)
  );

endmodule

`default_nettype wire

//--- hdl/frame_reader.sv
`default_nettype none

`include "splicer_defines.svh"

module frame_reader (
  input  wire logic              aclk,
  input  wire logic              aresetn,
  input  wire logic              frame_ready,
  input  wire video_pkg::pixel_t rd_pixel_even,
  input  wire video_pkg::pixel_t rd_pixel_odd,
  input  wire logic              m_axis_tready,
  output logic                   rd_en,
  output buffer_pkg::beat_addr_t rd_addr,
  output video_pkg::beat_t       m_axis_tdata,
  output logic                   m_axis_tvalid,
  output logic                   m_axis_tuser,
  output logic                   m_axis_tlast,
  output logic                   frame_free
);

  localparam int line_beats = `SPLICER_LINE_BEATS;
  localparam buffer_pkg::beat_addr_t last_addr =
    buffer_pkg::beat_addr_t'(`SPLICER_FRAME_BEATS - 1);

  buffer_pkg::read_state_t state;
  buffer_pkg::beat_addr_t  addr;
  logic                    issued_all;
  logic                    pop;
  logic [1:0]              occupancy;
  video_pkg::beat_t        bank_beat;

  // beat coming back from the banks this cycle
  logic                    pend_valid;
  logic                    pend_user;
  logic                    pend_last;

  // skid entry behind the output register
  video_pkg::beat_t        skid_data;
  logic                    skid_valid;
  logic                    skid_user;
  logic                    skid_last;

  assign bank_beat = {rd_pixel_odd, rd_pixel_even};
  assign pop       = m_axis_tvalid && m_axis_tready;

  // beats held or in flight once this cycle's output leaves
  assign occupancy = 2'(m_axis_tvalid) + 2'(skid_valid) + 2'(pend_valid) - 2'(pop);

  assign rd_en   = (state == buffer_pkg::drain) && !issued_all && (occupancy < 2'd2);
  assign rd_addr = addr;

  ////////////////////
  // read FSM
  ////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state      <= buffer_pkg::idle;
      addr       <= '0;
      issued_all <= 1'b0;
      frame_free <= 1'b0;
    end else begin
      frame_free <= 1'b0;
      case (state)
        buffer_pkg::idle: begin
          if (frame_ready) begin
            addr       <= '0;
            issued_all <= 1'b0;
            state      <= buffer_pkg::drain;
          end
        end
        buffer_pkg::drain: begin
          if (rd_en) begin
            addr <= addr + 1'b1;
            if (addr == last_addr) begin
              issued_all <= 1'b1;
            end
          end
          // nothing left behind the beat that just left
          if (pop && issued_all && !skid_valid && !pend_valid) begin
            frame_free <= 1'b1;
            state      <= buffer_pkg::idle;
          end
        end
        default: state <= buffer_pkg::idle;
      endcase
    end
  end

  // markers follow the address of each read
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= rd_en;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      pend_user <= (addr == '0);
      pend_last <= ((int'(addr) % line_beats) == (line_beats - 1));
    end
  end

  ////////////////////
  // output and skid
  ////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_axis_tvalid <= 1'b0;
      m_axis_tuser  <= 1'b0;
      m_axis_tlast  <= 1'b0;
      skid_valid    <= 1'b0;
    end else if (!m_axis_tvalid || m_axis_tready) begin
      if (skid_valid) begin
        m_axis_tvalid <= 1'b1;
        m_axis_tuser  <= skid_user;
        m_axis_tlast  <= skid_last;
        skid_valid    <= pend_valid;
      end else begin
        m_axis_tvalid <= pend_valid;
        m_axis_tuser  <= pend_valid && pend_user;
        m_axis_tlast  <= pend_valid && pend_last;
      end
    end else if (pend_valid) begin
      // output stalled, park the returning beat
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!m_axis_tvalid || m_axis_tready) begin
      m_axis_tdata <= skid_valid ? skid_data : bank_beat;
    end
    if (pend_valid) begin
      skid_data <= bank_beat;
      skid_user <= pend_user;
      skid_last <= pend_last;
    end
  end

  // a stalled beat holds still
  assert property (@(posedge aclk) disable iff (!aresetn)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser)
       && $stable(m_axis_tlast)));

  // read pacing never lets a bank beat arrive into a full buffer
  assert property (@(posedge aclk) disable iff (!aresetn)
    (skid_valid && m_axis_tvalid && !m_axis_tready) |-> !pend_valid);

endmodule

`default_nettype wire

//--- hdl/pixel_bank.sv
`default_nettype none

`include "splicer_defines.svh"

module pixel_bank (
  input  wire logic                   aclk,
  input  wire logic                   wr_en,
  input  wire logic                   rd_en,
  input  wire buffer_pkg::beat_addr_t wr_addr,
  input  wire buffer_pkg::beat_addr_t rd_addr,
  input  wire video_pkg::pixel_t      wr_pixel,
  output video_pkg::pixel_t           rd_pixel
);

  // one pixel per beat address
  video_pkg::pixel_t mem [`SPLICER_FRAME_BEATS];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pixel;
    end
  end

  // registered read, data one cycle after rd_en
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_pixel <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- hdl/frame_writer.sv
`default_nettype none

`include "splicer_defines.svh"

module frame_writer (
  input  wire logic                   aclk,
  input  wire logic                   aresetn,
  input  wire video_pkg::beat_t       s_axis_tdata,
  input  wire logic                   s_axis_tvalid,
  input  wire logic                   s_axis_tuser,
  input  wire logic                   frame_free,
  output logic                        s_axis_tready,
  output logic                        wr_en,
  output logic                        frame_ready,
  output buffer_pkg::beat_addr_t      wr_addr,
  output video_pkg::pixel_t           wr_pixel_even,
  output video_pkg::pixel_t           wr_pixel_odd
);

  localparam buffer_pkg::beat_addr_t last_addr =
    buffer_pkg::beat_addr_t'(`SPLICER_FRAME_BEATS - 1);

  buffer_pkg::write_state_t state;
  buffer_pkg::beat_addr_t   beat_addr;
  logic                     take;

  // buffer is busy while a stored frame waits to be read out
  assign s_axis_tready = (state != buffer_pkg::hold);
  assign take          = s_axis_tvalid && s_axis_tready;

  // before sync only a tuser beat is stored, the rest is dropped
  assign wr_en = take && ((state == buffer_pkg::fill) || s_axis_tuser);

  assign wr_addr       = beat_addr;
  assign wr_pixel_even = s_axis_tdata[`SPLICER_PIXEL_W-1:0];
  assign wr_pixel_odd  = s_axis_tdata[2*`SPLICER_PIXEL_W-1:`SPLICER_PIXEL_W];

  ////////////////////
  // write FSM
  ////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state       <= buffer_pkg::wait_sof;
      beat_addr   <= '0;
      frame_ready <= 1'b0;
    end else begin
      frame_ready <= 1'b0;
      case (state)
        buffer_pkg::wait_sof: begin
          // start beat lands at address 0
          if (wr_en) begin
            beat_addr <= beat_addr + 1'b1;
            state     <= buffer_pkg::fill;
          end
        end
        buffer_pkg::fill: begin
          if (wr_en) begin
            if (beat_addr == last_addr) begin
              beat_addr   <= '0;
              frame_ready <= 1'b1;
              state       <= buffer_pkg::hold;
            end else begin
              beat_addr <= beat_addr + 1'b1;
            end
          end
        end
        buffer_pkg::hold: begin
          if (frame_free) begin
            state <= buffer_pkg::wait_sof;
          end
        end
        default: state <= buffer_pkg::wait_sof;
      endcase
    end
  end

  // stored frame is protected until the reader releases it
  assert property (@(posedge aclk) disable iff (!aresetn)
    (state == buffer_pkg::hold) |-> !wr_en);

endmodule

`default_nettype wire

//--- hdl/buffer_pkg.sv
`default_nettype none

`include "splicer_defines.svh"

package buffer_pkg;

  // beat index inside the frame buffer
  typedef logic [`SPLICER_ADDR_W-1:0] beat_addr_t;

  ////////////////////
  // state machines
  ////////////////////

  // write side: sync to start of frame, fill, then wait for the reader
  typedef enum logic [1:0] {wait_sof, fill, hold} write_state_t;

  // read side
  typedef enum logic {idle, drain} read_state_t;

endpackage

`default_nettype wire

//--- hdl/video_pkg.sv
`default_nettype none

`include "splicer_defines.svh"

package video_pkg;

  ////////////////////
  // stream payload
  ////////////////////

  // one RGB pixel
  typedef logic [`SPLICER_PIXEL_W-1:0] pixel_t;

  // two pixels per beat, odd pixel in the upper half
  typedef logic [`SPLICER_BEAT_PIXELS*`SPLICER_PIXEL_W-1:0] beat_t;

endpackage

`default_nettype wire

//--- hdl/splicer_defines.svh
`ifndef SPLICER_DEFINES_SVH
`define SPLICER_DEFINES_SVH

// pixel format, one RGB pixel
`define SPLICER_PIXEL_W 24

// frame geometry in pixels
`define SPLICER_FRAME_W 8
`define SPLICER_FRAME_H 4

// two pixels travel in each beat
`define SPLICER_BEAT_PIXELS 2

// geometry in beats
`define SPLICER_LINE_BEATS (`SPLICER_FRAME_W / `SPLICER_BEAT_PIXELS)
`define SPLICER_FRAME_BEATS (`SPLICER_LINE_BEATS * `SPLICER_FRAME_H)

// enough bits to index every beat of a frame
`define SPLICER_ADDR_W 4

`endif
